//--- verilog.f
logic/csr_pkg.sv
logic/csr_write_if.sv
logic/csr_mode_regs.sv
logic/csr_timer.sv
logic/csr_interrupt.sv
logic/csr_save_regs.sv
logic/csr_read_mux.sv
logic/csr_top.sv
testbench/csr_tb.sv

//--- testbench/csr_tb.sv
`default_nettype none

module csr_tb import csr_pkg::*; ();

    localparam int          PERIOD       = 20;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] FULL_MASK    = 32'hffff_ffff;

    typedef enum {ACT_WRITE, ACT_READ, ACT_EXCEPTION, ACT_ERTN, ACT_SET_HW, ACT_WAIT_BIT} action_e;
    typedef enum {SIG_RVALUE, SIG_EX_ENTRY, SIG_ERTN_ENTRY, SIG_HAS_INT} signal_e;

    // For reads, mask selects the compared bits; for bit waits, value holds the bit index
    typedef struct {
        action_e     act;
        signal_e     sig;
        csr_num_e    num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] expected;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esub;
        int          wait_cycles;
    } step_t;

    logic                  clk;
    logic                  reset;
    logic [CSR_NUM_W-1:0]  csr_num;
    logic                  csr_we;
    logic [DATA_W-1:0]     csr_wmask;
    logic [DATA_W-1:0]     csr_wvalue;
    logic                  wb_ex;
    logic [ECODE_W-1:0]    wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    logic [DATA_W-1:0]     wb_pc;
    logic                  ertn_flush;
    logic [7:0]            hw_int;
    logic                  ipi_int;
    logic [DATA_W-1:0]     csr_rvalue;
    logic [DATA_W-1:0]     ex_entry;
    logic [DATA_W-1:0]     ertn_entry;
    logic                  has_int;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    fail_count  = 0;

    csr_top #(.SAVE_COUNT(MAX_SAVE)) i_csr_top (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .ertn_flush, .hw_int, .ipi_int,
        .csr_rvalue, .ex_entry, .ertn_entry, .has_int
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run exceeded its budget of %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic step_t make_step(action_e act, signal_e sig, csr_num_e num,
                                        logic [31:0] mask, logic [31:0] value,
                                        logic [31:0] expected, int wait_cycles);
        step_t s;
        s.act         = act;
        s.sig         = sig;
        s.num         = num;
        s.mask        = mask;
        s.value       = value;
        s.expected    = expected;
        s.pc          = '0;
        s.ecode       = '0;
        s.esub        = '0;
        s.wait_cycles = wait_cycles;
        return s;
    endfunction

    function automatic void add_write(csr_num_e num, logic [31:0] mask, logic [31:0] value);
        steps.push_back(make_step(ACT_WRITE, SIG_RVALUE, num, mask, value, '0, 0));
    endfunction

    function automatic void add_read(signal_e sig, csr_num_e num, logic [31:0] mask,
                                     logic [31:0] expected, int wait_cycles);
        steps.push_back(make_step(ACT_READ, sig, num, mask, '0, expected, wait_cycles));
    endfunction

    // A nonzero mask also issues a CSR write in the same cycle
    function automatic void add_exception(csr_num_e num, logic [31:0] mask, logic [31:0] value,
                                          logic [31:0] pc, ecode_e ecode, logic [8:0] esub);
        step_t s;
        s       = make_step(ACT_EXCEPTION, SIG_RVALUE, num, mask, value, '0, 0);
        s.pc    = pc;
        s.ecode = ecode;
        s.esub  = esub;
        steps.push_back(s);
    endfunction

    function automatic void add_event(action_e act, logic [31:0] value);
        steps.push_back(make_step(act, SIG_RVALUE, CSR_CRMD, '0, value, '0, 0));
    endfunction

    function automatic void add_wait_bit(csr_num_e num, int bit_idx, int budget);
        steps.push_back(make_step(ACT_WAIT_BIT, SIG_RVALUE, num, '0, bit_idx, '0, budget));
    endfunction

    task automatic build_table();
        // Reset state
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_read(SIG_RVALUE, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'hffff_ffff, 0);
        add_read(SIG_RVALUE, CSR_TCFG, FULL_MASK, 32'h0, 0);
        // Masked writes to the scratch registers
        add_write(CSR_SAVE0, FULL_MASK, 32'h1234_5678);
        add_write(CSR_SAVE0, 32'h0000_ffff, 32'haaaa_bbbb);
        add_write(CSR_SAVE1, 32'hff00_ff00, 32'hdead_beef);
        add_write(CSR_SAVE2, FULL_MASK, 32'hcafe_f00d);
        add_write(CSR_SAVE3, 32'h0f0f_0f0f, 32'h5555_5555);
        add_read(SIG_RVALUE, CSR_SAVE0, FULL_MASK, 32'h1234_bbbb, 0);
        add_read(SIG_RVALUE, CSR_SAVE1, FULL_MASK, 32'hde00_be00, 0);
        add_read(SIG_RVALUE, CSR_SAVE2, FULL_MASK, 32'hcafe_f00d, 0);
        add_read(SIG_RVALUE, CSR_SAVE3, FULL_MASK, 32'h0505_0505, 0);
        // EENTRY low six bits are hardwired
        add_write(CSR_EENTRY, FULL_MASK, 32'h1c00_803f);
        add_read(SIG_RVALUE, CSR_EENTRY, FULL_MASK, 32'h1c00_8000, 0);
        add_write(CSR_EENTRY, 32'h0000_ff00, 32'h0000_12ff);
        add_read(SIG_RVALUE, CSR_EENTRY, FULL_MASK, 32'h1c00_1200, 0);
        add_read(SIG_EX_ENTRY, CSR_EENTRY, FULL_MASK, 32'h1c00_1200, 0);
        // Exception entry from PLV 3 with IE set
        add_write(CSR_CRMD, 32'h7, 32'h7);
        add_read(SIG_RVALUE, CSR_CRMD, FULL_MASK, 32'h7, 0);
        add_exception(CSR_CRMD, '0, '0, 32'h1c00_0100, ECODE_SYS, 9'h005);
        add_read(SIG_RVALUE, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_read(SIG_RVALUE, CSR_PRMD, FULL_MASK, 32'h7, 0);
        add_read(SIG_RVALUE, CSR_ERA, FULL_MASK, 32'h1c00_0100, 0);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h7fff_0000, 32'h014b_0000, 0);
        // Return restores the saved mode
        add_event(ACT_ERTN, '0);
        add_read(SIG_RVALUE, CSR_CRMD, FULL_MASK, 32'h7, 0);
        add_read(SIG_ERTN_ENTRY, CSR_CRMD, FULL_MASK, 32'h1c00_0100, 0);
        // ERA write loses to an exception on the same edge
        add_exception(CSR_ERA, FULL_MASK, 32'hdead_beef, 32'h1c00_0200, ECODE_ADE, 9'h001);
        add_read(SIG_RVALUE, CSR_ERA, FULL_MASK, 32'h1c00_0200, 0);
        add_read(SIG_ERTN_ENTRY, CSR_ERA, FULL_MASK, 32'h1c00_0200, 0);
        add_read(SIG_RVALUE, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_read(SIG_RVALUE, CSR_PRMD, FULL_MASK, 32'h7, 0);
        // Software interrupt gated by CRMD.IE
        add_write(CSR_ESTAT, 32'h3, 32'h1);
        add_write(CSR_ECFG, 32'h1fff, 32'h1);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h3, 32'h1, 0);
        add_read(SIG_RVALUE, CSR_ECFG, FULL_MASK, 32'h1, 0);
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_write(CSR_CRMD, 32'h4, 32'h4);
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h1, 0);
        add_write(CSR_ESTAT, 32'h1, 32'h0);
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h0, 0);
        // hw_int[3] lands in IS[5]
        add_event(ACT_SET_HW, 32'h08);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h1fff, 32'h20, 0);
        add_write(CSR_ECFG, 32'h1fff, 32'h20);
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h1, 0);
        add_write(CSR_ECFG, 32'h20, 32'h0);
        add_read(SIG_HAS_INT, CSR_CRMD, FULL_MASK, 32'h0, 0);
        add_event(ACT_SET_HW, 32'h00);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h20, 32'h0, 0);
        // One-shot timer, INITVAL 5
        add_write(CSR_TCFG, FULL_MASK, 32'h15);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'd20, 0);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'd16, 3);
        add_wait_bit(CSR_ESTAT, TIMER_IS_BIT, 20);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'hffff_ffff, 0);
        add_write(CSR_TICLR, 32'h1, 32'h1);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h800, 32'h0, 0);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'hffff_ffff, 0);
        // Periodic mode reloads on expiry
        add_write(CSR_TCFG, FULL_MASK, 32'h17);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h800, 32'h0, 18);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'd1, 0);
        add_wait_bit(CSR_ESTAT, TIMER_IS_BIT, 5);
        add_read(SIG_RVALUE, CSR_TVAL, FULL_MASK, 32'd19, 0);
        add_write(CSR_TCFG, 32'h1, 32'h0);
        add_write(CSR_TICLR, 32'h1, 32'h1);
        add_read(SIG_RVALUE, CSR_ESTAT, 32'h800, 32'h0, 0);
    endtask

    task automatic check_read(input step_t s);
        case (s.sig)
            SIG_EX_ENTRY:   check_value("ex_entry", ex_entry, s.expected);
            SIG_ERTN_ENTRY: check_value("ertn_entry", ertn_entry, s.expected);
            SIG_HAS_INT:    check_value("has_int", {31'b0, has_int}, s.expected);
            default: begin
                check_value($sformatf("csr_rvalue[0x%0h]", s.num), csr_rvalue & s.mask,
                            s.expected);
            end
        endcase
    endtask

    // Starts and ends on a falling edge
    task automatic run_step(input step_t s);
        int polls;
        polls      = 0;
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        csr_num    = s.num;
        csr_wmask  = s.mask;
        csr_wvalue = s.value;
        case (s.act)
            ACT_WRITE:  csr_we = 1'b1;
            ACT_ERTN:   ertn_flush = 1'b1;
            ACT_SET_HW: hw_int = s.value[7:0];
            ACT_EXCEPTION: begin
                csr_we      = |s.mask;
                wb_ex       = 1'b1;
                wb_pc       = s.pc;
                wb_ecode    = s.ecode;
                wb_esubcode = s.esub;
            end
            ACT_READ: begin
                repeat (s.wait_cycles) @(negedge clk);
                #(PERIOD / 4);
                check_read(s);
            end
            ACT_WAIT_BIT: begin
                #(PERIOD / 4);
                while (!csr_rvalue[s.value[4:0]]) begin
                    if (polls >= s.wait_cycles) begin
                        fail_count++;
                        $display("Bit %0d of CSR 0x%0h never set within %0d cycles",
                                 s.value, s.num, s.wait_cycles);
                        $display("Test FAILED");
                        $fatal(1, "bit wait expired");
                    end
                    @(negedge clk);
                    #(PERIOD / 4);
                    polls++;
                end
            end
            default: ;
        endcase
        @(negedge clk);
    endtask

    initial begin
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        hw_int      = '0;
        ipi_int     = 1'b0;
        build_table();
        cycle_limit = RESET_CYCLES + 20 * steps.size();
        foreach (steps[i]) begin
            cycle_limit += steps[i].wait_cycles;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/csr_top.sv
`default_nettype none

module csr_top import csr_pkg::*; #(
    parameter int SAVE_COUNT = MAX_SAVE
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [CSR_NUM_W-1:0]  csr_num,
    input  logic                  csr_we,
    input  logic [DATA_W-1:0]     csr_wmask,
    input  logic [DATA_W-1:0]     csr_wvalue,
    input  logic                  wb_ex,
    input  logic [ECODE_W-1:0]    wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    input  logic [DATA_W-1:0]     wb_pc,
    input  logic                  ertn_flush,
    input  logic [7:0]            hw_int,
    input  logic                  ipi_int,
    output logic [DATA_W-1:0]     csr_rvalue,
    output logic [DATA_W-1:0]     ex_entry,
    output logic [DATA_W-1:0]     ertn_entry,
    output logic                  has_int
);

    logic [PLV_W-1:0]                  crmd_plv;
    logic                              crmd_ie;
    logic [PLV_W-1:0]                  prmd_pplv;
    logic                              prmd_pie;
    ecode_e                            estat_ecode;
    logic [ESUBCODE_W-1:0]             estat_esubcode;
    logic [DATA_W-1:0]                 era;
    logic [EENTRY_VA_W-1:0]            eentry_va;
    logic                              tcfg_en;
    logic                              tcfg_periodic;
    logic [TCFG_INITVAL_W-1:0]         tcfg_initval;
    logic [DATA_W-1:0]                 tval;
    logic                              timer_pending;
    logic [LIE_W-1:0]                  ecfg_lie;
    logic [IS_W-1:0]                   estat_is;
    logic [SAVE_COUNT-1:0][DATA_W-1:0] save_data;

    csr_write_if wr_if ();

    assign wr_if.we     = csr_we;
    assign wr_if.num    = csr_num_e'(csr_num);
    assign wr_if.wmask  = csr_wmask;
    assign wr_if.wvalue = csr_wvalue;

    csr_mode_regs i_mode_regs (
        .clk, .reset, .wr(wr_if.sink),
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .ertn_flush,
        .crmd_plv, .crmd_ie, .prmd_pplv, .prmd_pie,
        .estat_ecode, .estat_esubcode, .era, .eentry_va,
        .ex_entry, .ertn_entry
    );

    csr_timer i_timer (
        .clk, .reset, .wr(wr_if.sink),
        .tcfg_en, .tcfg_periodic, .tcfg_initval, .tval, .timer_pending
    );

    csr_interrupt i_interrupt (
        .clk, .reset, .wr(wr_if.sink),
        .hw_int, .ipi_int, .timer_pending, .crmd_ie,
        .ecfg_lie, .estat_is, .has_int
    );

    csr_save_regs #(.SAVE_COUNT(SAVE_COUNT)) i_save_regs (
        .clk, .reset, .wr(wr_if.sink), .save_data
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) i_read_mux (
        .wr(wr_if.sink),
        .crmd_plv, .crmd_ie, .prmd_pplv, .prmd_pie,
        .estat_ecode, .estat_esubcode, .estat_is, .era, .eentry_va,
        .ecfg_lie, .tcfg_en, .tcfg_periodic, .tcfg_initval, .tval,
        .save_data, .csr_rvalue
    );

endmodule

`default_nettype wire

//--- logic/csr_read_mux.sv
`default_nettype none

module csr_read_mux import csr_pkg::*; #(
    parameter int SAVE_COUNT = MAX_SAVE
) (
    csr_write_if.sink                         wr,
    input  logic [PLV_W-1:0]                  crmd_plv,
    input  logic                              crmd_ie,
    input  logic [PLV_W-1:0]                  prmd_pplv,
    input  logic                              prmd_pie,
    input  ecode_e                            estat_ecode,
    input  logic [ESUBCODE_W-1:0]             estat_esubcode,
    input  logic [IS_W-1:0]                   estat_is,
    input  logic [DATA_W-1:0]                 era,
    input  logic [EENTRY_VA_W-1:0]            eentry_va,
    input  logic [LIE_W-1:0]                  ecfg_lie,
    input  logic                              tcfg_en,
    input  logic                              tcfg_periodic,
    input  logic [TCFG_INITVAL_W-1:0]         tcfg_initval,
    input  logic [DATA_W-1:0]                 tval,
    input  logic [SAVE_COUNT-1:0][DATA_W-1:0] save_data,
    output logic [DATA_W-1:0]                 csr_rvalue
);

    logic [DATA_W-1:0]    crmd_word;
    logic [DATA_W-1:0]    prmd_word;
    logic [DATA_W-1:0]    estat_word;
    logic [DATA_W-1:0]    eentry_word;
    logic [DATA_W-1:0]    ecfg_word;
    logic [DATA_W-1:0]    tcfg_word;
    logic [CSR_NUM_W-1:0] save_idx;

    assign save_idx = wr.num - CSR_SAVE0;

    // Unused fields read as zero
    always_comb begin
        crmd_word                              = '0;
        crmd_word[PLV_LO +: PLV_W]             = crmd_plv;
        crmd_word[IE_BIT]                      = crmd_ie;
        prmd_word                              = '0;
        prmd_word[PPLV_LO +: PLV_W]            = prmd_pplv;
        prmd_word[PIE_BIT]                     = prmd_pie;
        estat_word                             = '0;
        estat_word[IS_LO +: IS_W]              = estat_is;
        estat_word[ECODE_LO +: ECODE_W]        = estat_ecode;
        estat_word[ESUBCODE_LO +: ESUBCODE_W]  = estat_esubcode;
        eentry_word                            = '0;
        eentry_word[EENTRY_VA_LO +: EENTRY_VA_W] = eentry_va;
        ecfg_word                              = '0;
        ecfg_word[LIE_LO +: LIE_W]             = ecfg_lie;
        tcfg_word                              = '0;
        tcfg_word[TCFG_EN_BIT]                 = tcfg_en;
        tcfg_word[TCFG_PERIODIC_BIT]           = tcfg_periodic;
        tcfg_word[TCFG_INITVAL_LO +: TCFG_INITVAL_W] = tcfg_initval;
    end

    always_comb begin
        csr_rvalue = '0;
        case (wr.num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = prmd_word;
            CSR_ECFG:   csr_rvalue = ecfg_word;
            CSR_ESTAT:  csr_rvalue = estat_word;
            CSR_ERA:    csr_rvalue = era;
            CSR_EENTRY: csr_rvalue = eentry_word;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
                if (save_idx < SAVE_COUNT) begin
                    csr_rvalue = save_data[save_idx];
                end
            end
            CSR_TCFG:   csr_rvalue = tcfg_word;
            CSR_TVAL:   csr_rvalue = tval;
            // Clear bit is write-only
            CSR_TICLR:  csr_rvalue = '0;
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/csr_save_regs.sv
`default_nettype none

module csr_save_regs import csr_pkg::*; #(
    parameter int SAVE_COUNT = MAX_SAVE
) (
    input  logic                               clk,
    input  logic                               reset,
    csr_write_if.sink                          wr,
    output logic [SAVE_COUNT-1:0][DATA_W-1:0]  save_data
);

    logic [CSR_NUM_W-1:0] save_idx;

    if (SAVE_COUNT < 1 || SAVE_COUNT > MAX_SAVE) begin : g_bad_count
        $error("SAVE_COUNT must be between 1 and %0d", MAX_SAVE);
    end

    // Numbers below SAVE0 wrap to large indices and miss
    assign save_idx = wr.num - CSR_SAVE0;

    always_ff @(posedge clk) begin
        if (reset) begin
            save_data <= '0;
        end else if (wr.we && save_idx < SAVE_COUNT) begin
            save_data[save_idx] <= masked_merge(save_data[save_idx], wr.wmask, wr.wvalue);
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_interrupt.sv
`default_nettype none

module csr_interrupt import csr_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    csr_write_if.sink        wr,
    input  logic [7:0]       hw_int,
    input  logic             ipi_int,
    input  logic             timer_pending,
    input  logic             crmd_ie,
    output logic [LIE_W-1:0] ecfg_lie,
    output logic [IS_W-1:0]  estat_is,
    output logic             has_int
);

    logic [DATA_W-1:0] ecfg_merged;
    logic [DATA_W-1:0] estat_merged;
    logic [1:0]        sw_is;
    logic [7:0]        hw_is;
    logic              ipi_is;

    assign ecfg_merged  = masked_merge({19'b0, ecfg_lie}, wr.wmask, wr.wvalue);
    assign estat_merged = masked_merge({30'b0, sw_is}, wr.wmask, wr.wvalue);

    // LIE bit 10 has no source behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wr.we && wr.num == CSR_ECFG) begin
            ecfg_lie <= ecfg_merged[LIE_LO +: LIE_W] & ~(LIE_W'(1) << LIE_RSVD_BIT);
        end
    end

    // Only IS[1:0] is writable through ESTAT
    always_ff @(posedge clk) begin
        if (reset) begin
            sw_is  <= '0;
            hw_is  <= '0;
            ipi_is <= 1'b0;
        end else begin
            hw_is  <= hw_int;
            ipi_is <= ipi_int;
            if (wr.we && wr.num == CSR_ESTAT) begin
                sw_is <= estat_merged[IS_LO +: 2];
            end
        end
    end

    always_comb begin
        estat_is               = '0;
        estat_is[1:0]          = sw_is;
        estat_is[9:2]          = hw_is;
        estat_is[TIMER_IS_BIT] = timer_pending;
        estat_is[12]           = ipi_is;
    end

    assign has_int = crmd_ie && |(estat_is[IS_W-2:0] & ecfg_lie[LIE_W-2:0]);

    a_has_int_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(has_int)
    );

endmodule

`default_nettype wire

//--- logic/csr_timer.sv
`default_nettype none

module csr_timer import csr_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    csr_write_if.sink                 wr,
    output logic                      tcfg_en,
    output logic                      tcfg_periodic,
    output logic [TCFG_INITVAL_W-1:0] tcfg_initval,
    output logic [DATA_W-1:0]         tval,
    output logic                      timer_pending
);

    logic [DATA_W-1:0] tcfg_merged;
    logic              tcfg_hit;
    logic              ticlr_clear;
    logic              expire;

    assign tcfg_merged = masked_merge({tcfg_initval, tcfg_periodic, tcfg_en},
                                      wr.wmask, wr.wvalue);
    assign tcfg_hit    = wr.we && wr.num == CSR_TCFG;
    assign ticlr_clear = wr.we && wr.num == CSR_TICLR
                      && wr.wmask[TICLR_CLR_BIT] && wr.wvalue[TICLR_CLR_BIT];
    assign expire      = tcfg_en && tval == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_hit) begin
            tcfg_en       <= tcfg_merged[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_merged[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_merged[TCFG_INITVAL_LO +: TCFG_INITVAL_W];
        end
    end

    // Counter parks at all ones once a one-shot run is done
    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '1;
        end else if (tcfg_hit && tcfg_merged[TCFG_EN_BIT]) begin
            tval <= {tcfg_merged[TCFG_INITVAL_LO +: TCFG_INITVAL_W], 2'b00};
        end else if (tcfg_en && tval != '1) begin
            if (expire && tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b00};
            end else begin
                tval <= tval - 1'b1;
            end
        end
    end

    // Expiry beats a clear on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (expire) begin
            timer_pending <= 1'b1;
        end else if (ticlr_clear) begin
            timer_pending <= 1'b0;
        end
    end

    a_no_count_when_disabled: assert property (
        @(posedge clk) disable iff (reset) (!tcfg_en && !tcfg_hit) |=> $stable(tval)
    );

endmodule

`default_nettype wire

//--- logic/csr_mode_regs.sv
`default_nettype none

module csr_mode_regs import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    csr_write_if.sink              wr,
    input  logic                   wb_ex,
    input  logic [ECODE_W-1:0]     wb_ecode,
    input  logic [ESUBCODE_W-1:0]  wb_esubcode,
    input  logic [DATA_W-1:0]      wb_pc,
    input  logic                   ertn_flush,
    output logic [PLV_W-1:0]       crmd_plv,
    output logic                   crmd_ie,
    output logic [PLV_W-1:0]       prmd_pplv,
    output logic                   prmd_pie,
    output ecode_e                 estat_ecode,
    output logic [ESUBCODE_W-1:0]  estat_esubcode,
    output logic [DATA_W-1:0]      era,
    output logic [EENTRY_VA_W-1:0] eentry_va,
    output logic [DATA_W-1:0]      ex_entry,
    output logic [DATA_W-1:0]      ertn_entry
);

    logic [DATA_W-1:0] crmd_merged;
    logic [DATA_W-1:0] prmd_merged;
    logic [DATA_W-1:0] era_merged;
    logic [DATA_W-1:0] eentry_merged;

    assign crmd_merged   = masked_merge({29'b0, crmd_ie, crmd_plv}, wr.wmask, wr.wvalue);
    assign prmd_merged   = masked_merge({29'b0, prmd_pie, prmd_pplv}, wr.wmask, wr.wvalue);
    assign era_merged    = masked_merge(era, wr.wmask, wr.wvalue);
    assign eentry_merged = masked_merge({eentry_va, 6'b0}, wr.wmask, wr.wvalue);

    // Exception first, then return, then a CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == CSR_CRMD) begin
            crmd_plv <= crmd_merged[PLV_LO +: PLV_W];
            crmd_ie  <= crmd_merged[IE_BIT];
        end
    end

    // PRMD and ERA hold across ertn
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
            era       <= '0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= wb_pc;
        end else if (!ertn_flush && wr.we) begin
            if (wr.num == CSR_PRMD) begin
                prmd_pplv <= prmd_merged[PPLV_LO +: PLV_W];
                prmd_pie  <= prmd_merged[PIE_BIT];
            end
            if (wr.num == CSR_ERA) begin
                era <= era_merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode    <= ECODE_INT;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= ecode_e'(wb_ecode);
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (wr.we && wr.num == CSR_EENTRY) begin
            eentry_va <= eentry_merged[EENTRY_VA_LO +: EENTRY_VA_W];
        end
    end

    assign ex_entry   = {eentry_va, 6'b0};
    assign ertn_entry = era;

    // The writeback stage never raises an exception and a return together
    a_ex_ertn_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(wb_ex && ertn_flush)
    );

endmodule

`default_nettype wire

//--- logic/csr_write_if.sv
`default_nettype none

interface csr_write_if import csr_pkg::*; ();

    logic              we;
    csr_num_e          num;
    logic [DATA_W-1:0] wmask;
    logic [DATA_W-1:0] wvalue;

    modport source (
        output we, num, wmask, wvalue
    );

    // num doubles as the read number
    modport sink (
        input we, num, wmask, wvalue
    );

endinterface

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int DATA_W    = 32;
    localparam int CSR_NUM_W = 14;

    // CRMD and PRMD
    localparam int PLV_LO  = 0;
    localparam int PLV_W   = 2;
    localparam int IE_BIT  = 2;
    localparam int PPLV_LO = PLV_LO;
    localparam int PIE_BIT = IE_BIT;

    localparam int EENTRY_VA_LO = 6;
    localparam int EENTRY_VA_W  = 26;

    // ESTAT
    localparam int IS_LO       = 0;
    localparam int IS_W        = 13;
    localparam int ECODE_LO    = 16;
    localparam int ECODE_W     = 6;
    localparam int ESUBCODE_LO = 22;
    localparam int ESUBCODE_W  = 9;

    // ECFG, bit 10 is reserved
    localparam int LIE_LO       = 0;
    localparam int LIE_W        = 13;
    localparam int LIE_RSVD_BIT = 10;

    // Timer
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TCFG_INITVAL_W    = 30;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int TIMER_IS_BIT      = 11;

    localparam int MAX_SAVE = 4;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT  = 6'h00,
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_PIF  = 6'h03,
        ECODE_PME  = 6'h04,
        ECODE_PPI  = 6'h07,
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d,
        ECODE_IPE  = 6'h0e,
        ECODE_FPD  = 6'h0f,
        ECODE_TLBR = 6'h3f
    } ecode_e;

    // Masked bits take the new value, the others keep the old one
    function automatic logic [DATA_W-1:0] masked_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] wmask,
        input logic [DATA_W-1:0] wvalue
    );
        return (wmask & wvalue) | (~wmask & old_word);
    endfunction

endpackage

`default_nettype wire
